// File: project.f
source/dds_lab_pkg.sv
source/key_state_tracker.sv
source/lfsr_bit_source.sv
source/dds_wave_generator.sv
source/wave_modulator.sv
source/dds_axil_regs.sv
source/dds_lab_top.sv
testbench/dds_lab_sva.sv
testbench/tb_dds_lab.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f \
   --top-module tb_dds_lab --Mdir obj_dir -o tb_dds_lab
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_dds_lab > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Regression failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
   echo "no result line found in $LOG"
   exit 1
fi
exit 0

// File: testbench/tb_dds_lab.sv
`timescale 1ns/1ps

module tb_dds_lab
   import dds_lab_pkg::*;
();

   // phase lengths in cycles
   localparam int WAVE_RUN     = 40;
   localparam int HOLD_RUN     = 12;
   localparam int MOD_RUN      = 120;
   localparam int LFSR_READS   = 10;
   localparam int LFSR_GAP_MAX = 64;
   localparam int KEY_EVENTS   = 60;
   localparam int MIX_OPS      = 30;
   localparam int TXN_CYCLES   = 12;   // generous per bus transfer with stalls
   localparam int N_TXN        = 5 + 16 + 4 + LFSR_READS + KEY_EVENTS / 10 + 2 * MIX_OPS;
   localparam int PLANNED      = N_TXN * TXN_CYCLES + 4 * (WAVE_RUN + HOLD_RUN)
                                 + 4 * MOD_RUN + LFSR_READS * LFSR_GAP_MAX + KEY_EVENTS + 8;
   localparam int CYCLE_LIMIT  = 2 * PLANNED;

   logic       CLK_25MHZ;
   logic       reset_from_key;
   axil_addr_t awaddr;
   logic       awvalid;
   logic       awready;
   axil_data_t wdata;
   logic [3:0] wstrb;
   logic       wvalid;
   logic       wready;
   logic [1:0] bresp;
   logic       bvalid;
   logic       bready;
   axil_addr_t araddr;
   logic       arvalid;
   logic       arready;
   axil_data_t rdata;
   logic [1:0] rresp;
   logic       rvalid;
   logic       rready;
   logic       kbd_event_valid;
   kbd_event_t kbd_event;
   sample_t    wave_out;
   sample_t    mod_out;

   // reference model state
   dds_ctrl_t  m_ctrl;
   phase_t     m_inc;
   phase_t     m_phase;
   sample_t    m_wave;
   sample_t    m_mod;
   logic [4:0] m_lfsr;
   int         m_tick;
   key_vec_t   m_keys;
   logic       m_bvalid;

   int seed = 90;
   int cycles = 0;
   int data_errs = 0;
   int bus_errs = 0;
   int read_errs = 0;

   dds_lab_top DUT (.*);

   bind dds_axil_regs dds_lab_sva handshake_chk (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .awready        (awready),
      .bvalid         (bvalid),
      .bready         (bready),
      .arready        (arready),
      .rvalid         (rvalid),
      .rready         (rready)
   );

   always #20 CLK_25MHZ = ~CLK_25MHZ;

   ///////////////////////////////////////////////////////////////////////////
   // model functions
   ///////////////////////////////////////////////////////////////////////////

   function automatic sample_t wave_shape(wave_sel_e sel, phase_t ph);
      logic [11:0] p;
      logic [10:0] fold;
      p    = ph[31:20];
      fold = p[11] ? 11'(2047 - p[10:0]) : p[10:0];   // falling half mirrored
      case (sel)
         WAVE_SAW:      return sample_t'(p - 12'd2048);
         WAVE_SAW_INV:  return sample_t'(12'd2048 - p);
         WAVE_TRIANGLE: return sample_t'({fold, 1'b0} - 12'd2048);
         default:       return p[11] ? sample_t'(12'h800) : sample_t'(12'h7FF);
      endcase
   endfunction

   function automatic sample_t modulate(mod_sel_e sel, sample_t w, logic b);
      case (sel)
         MOD_ASK:      return b ? w : sample_t'(12'h000);
         MOD_BPSK:     return b ? sample_t'(12'd0 - w) : w;
         MOD_LFSR_BIT: return b ? sample_t'(12'h800) : sample_t'(12'h000);
         default:      return sample_t'(12'h000);
      endcase
   endfunction

   function automatic axil_data_t reg_value(axil_addr_t a);
      case (a)
         4'h0:    return {27'd0, m_ctrl};
         4'h4:    return m_inc;
         4'h8:    return {15'd0, m_keys};
         4'hC:    return {27'd0, m_lfsr};
         default: return '0;
      endcase
   endfunction

   function automatic int random_range(int n);
      return int'({$random(seed)} % n);
   endfunction

   function automatic logic random_bit();
      return 1'(random_range(2));
   endfunction

   ///////////////////////////////////////////////////////////////////////////
   // model update and output checks 1 ns after each edge
   ///////////////////////////////////////////////////////////////////////////

   always @(posedge CLK_25MHZ)
   begin
      dds_ctrl_t  o_ctrl;
      phase_t     o_inc;
      phase_t     o_phase;
      sample_t    o_wave;
      logic [4:0] o_lfsr;
      int         key_id;
      #1;   // inputs still hold the values sampled at the edge
      o_ctrl  = m_ctrl;
      o_inc   = m_inc;
      o_phase = m_phase;
      o_wave  = m_wave;
      o_lfsr  = m_lfsr;
      key_id  = int'(kbd_event[6:0]);
      if (reset_from_key)
      begin
         m_ctrl   = '0;
         m_inc    = '0;
         m_phase  = '0;
         m_wave   = '0;
         m_mod    = '0;
         m_lfsr   = 5'b00001;
         m_tick   = 0;
         m_keys   = '0;
         m_bvalid = 1'b0;
      end
      else
      begin
         if (awvalid && wvalid && !m_bvalid)
         begin
            if (awaddr == 4'h0)
               m_ctrl = dds_ctrl_t'(wdata[4:0]);
            else if (awaddr == 4'h4)
               m_inc = wdata;
            m_bvalid = 1'b1;
         end
         else if (bready)
         begin
            m_bvalid = 1'b0;
         end
         if (o_ctrl.enable)
         begin
            m_phase = o_phase + o_inc;
            m_wave  = wave_shape(o_ctrl.wave_sel, o_phase);
         end
         m_mod = modulate(o_ctrl.mod_sel, o_wave, o_lfsr[0]);
         if (m_tick == 49)   // 50 clocks per step
         begin
            m_tick = 0;
            m_lfsr = {o_lfsr[3:0], o_lfsr[4] ^ o_lfsr[2]};
         end
         else
         begin
            m_tick = m_tick + 1;
         end
         if (kbd_event_valid && key_id >= 1 && key_id <= 17)
            m_keys[17 - key_id] = ~kbd_event[7];
      end
      assert (wave_out == m_wave)
         else
         begin
            data_errs++;
            $display("** Error at %0t: wave_out %h, expected %h", $time, wave_out, m_wave);
         end
      assert (mod_out == m_mod)
         else
         begin
            data_errs++;
            $display("** Error at %0t: mod_out %h, expected %h", $time, mod_out, m_mod);
         end
      assert (bvalid == m_bvalid)
         else
         begin
            bus_errs++;
            $display("** Error at %0t: bvalid %b, expected %b", $time, bvalid, m_bvalid);
         end
   end

   // watchdog
   always @(posedge CLK_25MHZ)
   begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Regression failed");
         $finish;
      end
   end

   ///////////////////////////////////////////////////////////////////////////
   // bus tasks entered 2 ns after an edge
   ///////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge CLK_25MHZ);
      #2;
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic present_write(input axil_addr_t a, input axil_data_t d);
      logic done;
      awaddr  = a;
      wdata   = d;
      wstrb   = 4'hF;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      done    = 1'b0;
      while (!done)
      begin
         #1;
         done = awready;
         assert (wready == awready)
            else
            begin
               bus_errs++;
               $display("** Error at %0t: awready and wready differ", $time);
            end
         next_cycle();
      end
      awvalid = 1'b0;
      wvalid  = 1'b0;
   endtask

   task automatic take_bresp();
      logic done;
      done = 1'b0;
      while (!done)
      begin
         bready = random_bit();   // random stall
         #1;
         done = bvalid && bready;
         if (done)
         begin
            assert (bresp == 2'b00)
               else
               begin
                  bus_errs++;
                  $display("** Error at %0t: bresp %b, expected OKAY", $time, bresp);
               end
         end
         next_cycle();
      end
      bready = 1'b0;
   endtask

   task automatic axil_write(input axil_addr_t a, input axil_data_t d);
      present_write(a, d);
      take_bresp();
   endtask

   // second write waits behind the first response
   task automatic paired_writes(input axil_addr_t a0, input axil_data_t d0,
                                input axil_addr_t a1, input axil_data_t d1);
      present_write(a0, d0);
      awaddr  = a1;
      wdata   = d1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      take_bresp();
      axil_write(a1, d1);
   endtask

   task automatic request_read(input axil_addr_t a, output axil_data_t expected);
      logic done;
      araddr  = a;
      arvalid = 1'b1;
      done    = 1'b0;
      while (!done)
      begin
         #1;
         done     = arready;
         expected = reg_value(a);   // register contents just before the accept edge
         next_cycle();
      end
      arvalid = 1'b0;
   endtask

   task automatic check_rdata(input axil_addr_t a, input axil_data_t expected);
      logic done;
      done = 1'b0;
      while (!done)
      begin
         rready = random_bit();
         #1;
         done = rvalid && rready;
         if (done)
         begin
            assert (rdata == expected && rresp == 2'b00)
               else
               begin
                  read_errs++;
                  $display("** Error at %0t: read of %h gave %h, expected %h",
                           $time, a, rdata, expected);
               end
         end
         next_cycle();
      end
      rready = 1'b0;
   endtask

   task automatic read_check(input axil_addr_t a);
      axil_data_t expected;
      request_read(a, expected);
      check_rdata(a, expected);
   endtask

   // second read waits behind the first response
   task automatic overlapped_reads(input axil_addr_t a0, input axil_addr_t a1);
      axil_data_t expected;
      request_read(a0, expected);
      araddr  = a1;
      arvalid = 1'b1;
      check_rdata(a0, expected);
      read_check(a1);
   endtask

   ///////////////////////////////////////////////////////////////////////////
   // stimulus
   ///////////////////////////////////////////////////////////////////////////

   initial
   begin
      int total;
      CLK_25MHZ       = 1'b0;
      reset_from_key  = 1'b1;
      awaddr          = '0;
      awvalid         = 1'b0;
      wdata           = '0;
      wstrb           = 4'h0;
      wvalid          = 1'b0;
      bready          = 1'b0;
      araddr          = '0;
      arvalid         = 1'b0;
      rready          = 1'b0;
      kbd_event_valid = 1'b0;
      kbd_event       = '0;
      repeat (2) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;

      // reset values with the lfsr at its seed
      assert (wave_out == '0 && mod_out == '0)
         else
         begin
            data_errs++;
            $display("** Error at %0t: outputs not zero after reset", $time);
         end
      read_check(4'h0);
      read_check(4'h4);
      read_check(4'h8);
      read_check(4'hC);
      read_check(4'h2);   // unmapped

      for (int w = 0; w < 4; w++)
      begin
         axil_write(4'h4, axil_data_t'({$random(seed)}));
         axil_write(4'h0, {27'd0, 1'b1, 2'(random_range(4)), 2'(w)});
         idle(WAVE_RUN);
         read_check(4'h4);
         axil_write(4'h0, {27'd0, 1'b0, 2'(random_range(4)), 2'(w)});   // hold
         idle(HOLD_RUN);
      end

      for (int m = 0; m < 4; m++)
      begin
         axil_write(4'h0, {27'd0, 1'b1, 2'(m), 2'(random_range(4))});
         idle(MOD_RUN);
      end

      for (int i = 0; i < LFSR_READS; i++)
      begin
         idle(random_range(LFSR_GAP_MAX));
         read_check(4'hC);
      end

      // ids 0..20 with some out of range and mostly makes
      for (int i = 0; i < KEY_EVENTS; i++)
      begin
         kbd_event_valid = random_bit();
         kbd_event       = {random_range(3) == 0, 7'(random_range(21))};
         next_cycle();
         if (i % 10 == 9)
         begin
            kbd_event_valid = 1'b0;
            read_check(4'h8);
         end
      end
      kbd_event_valid = 1'b0;

      for (int i = 0; i < MIX_OPS; i++)
      begin
         case (random_range(4))
            0:
               axil_write(4'(random_range(16)), axil_data_t'({$random(seed)}));
            1:
               read_check(4'(random_range(16)));
            2:
               paired_writes(4'(random_range(16)), axil_data_t'({$random(seed)}),
                             4'(random_range(16)), axil_data_t'({$random(seed)}));
            default:
               overlapped_reads(4'(random_range(16)), 4'(random_range(16)));
         endcase
      end
      idle(4);

      total = data_errs + bus_errs + read_errs + DUT.u_regs.handshake_chk.fail_count;
      $display("error counts: datapath %0d, bus %0d, readback %0d, handshake %0d",
               data_errs, bus_errs, read_errs, DUT.u_regs.handshake_chk.fail_count);
      if (total == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: testbench/dds_lab_sva.sv
`timescale 1ns/1ps

module dds_lab_sva
(
   input logic CLK_25MHZ,
   input logic reset_from_key,
   input logic awready,
   input logic bvalid,
   input logic bready,
   input logic arready,
   input logic rvalid,
   input logic rready
);

   int fail_count = 0;   // read by the testbench summary

   ///////////////////////////////////////////////////////////////////////////
   // response channels hold until taken
   ///////////////////////////////////////////////////////////////////////////

   bvalid_hold: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      bvalid && !bready |=> bvalid)
      else
      begin
         fail_count++;
         $error("bvalid dropped before bready was seen");
      end

   rvalid_hold: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      rvalid && !rready |=> rvalid)
      else
      begin
         fail_count++;
         $error("rvalid dropped before rready was seen");
      end

   // no new accept while a response is pending
   aw_blocked: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      bvalid |-> !awready)
      else
      begin
         fail_count++;
         $error("awready high while bvalid pending");
      end

   ar_blocked: assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      rvalid |-> !arready)
      else
      begin
         fail_count++;
         $error("arready high while rvalid pending");
      end

endmodule

// File: source/dds_lab_top.sv
`timescale 1ns/1ps

module dds_lab_top
   import dds_lab_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,

   // axi4-lite slave
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic [3:0] wstrb,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output axil_data_t rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready,

   // keyboard events
   input  logic       kbd_event_valid,
   input  kbd_event_t kbd_event,

   output sample_t    wave_out,
   output sample_t    mod_out
);

   dds_ctrl_t  ctrl;
   phase_t     phase_inc;
   key_vec_t   keys;
   logic [4:0] lfsr_state;
   logic       lfsr_bit;

   ////////////////////////////////////////////////////////////////////////////
   // control and readback
   ////////////////////////////////////////////////////////////////////////////

   dds_axil_regs u_regs (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .awaddr         (awaddr),
      .awvalid        (awvalid),
      .awready        (awready),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .wvalid         (wvalid),
      .wready         (wready),
      .bresp          (bresp),
      .bvalid         (bvalid),
      .bready         (bready),
      .araddr         (araddr),
      .arvalid        (arvalid),
      .arready        (arready),
      .rdata          (rdata),
      .rresp          (rresp),
      .rvalid         (rvalid),
      .rready         (rready),
      .ctrl           (ctrl),
      .phase_inc      (phase_inc),
      .keys           (keys),
      .lfsr_state     (lfsr_state)
   );

   key_state_tracker u_keys (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .kbd_event_valid (kbd_event_valid),
      .kbd_event       (kbd_event),
      .keys            (keys)
   );

   ////////////////////////////////////////////////////////////////////////////
   // signal path, wave then modulation
   ////////////////////////////////////////////////////////////////////////////

   lfsr_bit_source u_lfsr (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .lfsr_state     (lfsr_state),
      .lfsr_bit       (lfsr_bit)
   );

   dds_wave_generator u_dds (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .ctrl           (ctrl),
      .phase_inc      (phase_inc),
      .wave_out       (wave_out)
   );

   wave_modulator u_mod (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .ctrl           (ctrl),
      .wave           (wave_out),   // stage one feeds stage two
      .lfsr_bit       (lfsr_bit),
      .mod_out        (mod_out)
   );

endmodule

// File: source/dds_axil_regs.sv
`timescale 1ns/1ps

module dds_axil_regs
   import dds_lab_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,

   // write address / data / response
   input  axil_addr_t awaddr,
   input  logic       awvalid,
   output logic       awready,
   input  axil_data_t wdata,
   input  logic [3:0] wstrb,
   input  logic       wvalid,
   output logic       wready,
   output logic [1:0] bresp,
   output logic       bvalid,
   input  logic       bready,

   // read address / data
   input  axil_addr_t araddr,
   input  logic       arvalid,
   output logic       arready,
   output axil_data_t rdata,
   output logic [1:0] rresp,
   output logic       rvalid,
   input  logic       rready,

   // datapath side
   output dds_ctrl_t  ctrl,
   output phase_t     phase_inc,
   input  key_vec_t   keys,
   input  logic [4:0] lfsr_state
);

   logic       wr_accept;
   logic       rd_accept;
   axil_data_t rd_mux;

   ////////////////////////////////////////////////////////////////////////////
   // write channel
   ////////////////////////////////////////////////////////////////////////////

   // address and data accepted together with one transfer in flight
   assign wr_accept = awvalid && wvalid && !bvalid;
   assign awready   = wr_accept;
   assign wready    = wr_accept;
   assign bresp     = AXI_RESP_OKAY;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         ctrl      <= '0;
         phase_inc <= '0;
         bvalid    <= 1'b0;
      end
      else
      begin
         if (wr_accept)
         begin
            unique case (awaddr)
               REG_CTRL:      ctrl      <= dds_ctrl_t'(wdata[4:0]);
               REG_PHASE_INC: phase_inc <= wdata;
               default:       ;   // read only or unmapped addresses dropped
            endcase
         end

         if (wr_accept)
         begin
            bvalid <= 1'b1;
         end
         else if (bready)
         begin
            bvalid <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // read channel
   ////////////////////////////////////////////////////////////////////////////

   assign rd_accept = arvalid && !rvalid;
   assign arready   = rd_accept;
   assign rresp     = AXI_RESP_OKAY;

   always_comb
   begin
      unique case (araddr)
         REG_CTRL:      rd_mux = {27'd0, ctrl};
         REG_PHASE_INC: rd_mux = phase_inc;
         REG_KEYS:      rd_mux = {15'd0, keys};
         REG_LFSR:      rd_mux = {27'd0, lfsr_state};
         default:       rd_mux = '0;   // holes read as zero
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         rvalid <= 1'b0;
      end
      else if (rd_accept)
      begin
         rvalid <= 1'b1;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

   // read data captured at the accept edge
   always_ff @(posedge CLK_25MHZ)
   begin
      if (rd_accept)
      begin
         rdata <= rd_mux;
      end
   end

endmodule

// File: source/wave_modulator.sv
`timescale 1ns/1ps

module wave_modulator
   import dds_lab_pkg::*;
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  dds_ctrl_t ctrl,
   input  sample_t   wave,
   input  logic      lfsr_bit,
   output sample_t   mod_out
);

   sample_t mod_next;

   // second pipeline stage after the wave register
   always_comb
   begin
      unique case (ctrl.mod_sel)
         MOD_ASK:      mod_next = lfsr_bit ? wave : '0;          // on/off keying
         MOD_BPSK:     mod_next = lfsr_bit ? -wave : wave;       // phase flip
         MOD_LFSR_BIT: mod_next = lfsr_bit ? SAMPLE_MIN : '0;    // raw bit view
         MOD_OFF:      mod_next = '0;
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         mod_out <= '0;
      end
      else
      begin
         mod_out <= mod_next;
      end
   end

endmodule

// File: source/dds_wave_generator.sv
`timescale 1ns/1ps

module dds_wave_generator
   import dds_lab_pkg::*;
(
   input  logic      CLK_25MHZ,
   input  logic      reset_from_key,
   input  dds_ctrl_t ctrl,
   input  phase_t    phase_inc,
   output sample_t   wave_out
);

   phase_t      phase;
   logic [11:0] p;          // top of the phase
   logic [10:0] folded;
   sample_t     saw;
   sample_t     shape;

   assign p      = phase[31:20];
   assign saw    = {~p[11], p[10:0]};                   // offset binary to signed
   assign folded = p[11] ? ~p[10:0] : p[10:0];          // mirror second half

   always_comb
   begin
      unique case (ctrl.wave_sel)
         WAVE_SAW:      shape = saw;
         WAVE_SAW_INV:  shape = -saw;
         WAVE_TRIANGLE: shape = {~folded[10], folded[9:0], 1'b0};
         WAVE_SQUARE:   shape = p[11] ? SAMPLE_MIN : SAMPLE_MAX;
      endcase
   end

   // phase and output freeze together while disabled
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase    <= '0;
         wave_out <= '0;
      end
      else if (ctrl.enable)
      begin
         phase    <= phase + phase_inc;
         wave_out <= shape;   // from the phase before this edge
      end
   end

endmodule

// File: source/lfsr_bit_source.sv
`timescale 1ns/1ps

module lfsr_bit_source
   import dds_lab_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   output logic [4:0] lfsr_state,
   output logic       lfsr_bit
);

   logic [15:0] tick_cnt;
   logic        tick;
   logic        feedback;

   assign tick     = (tick_cnt == LFSR_TICK_DIV - 16'd1);
   assign feedback = ^(lfsr_state & LFSR_TAPS);   // bits 4 and 2

   // slow step, free running
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         tick_cnt   <= '0;
         lfsr_state <= LFSR_SEED;
      end
      else
      begin
         tick_cnt <= tick ? 16'd0 : tick_cnt + 16'd1;
         if (tick)
         begin
            lfsr_state <= {lfsr_state[3:0], feedback};   // shift left
         end
      end
   end

   assign lfsr_bit = lfsr_state[0];

endmodule

// File: source/key_state_tracker.sv
`timescale 1ns/1ps

module key_state_tracker
   import dds_lab_pkg::*;
(
   input  logic       CLK_25MHZ,
   input  logic       reset_from_key,
   input  logic       kbd_event_valid,
   input  kbd_event_t kbd_event,
   output key_vec_t   keys
);

   logic [6:0] key_id;
   logic       is_break;
   logic       id_in_range;
   logic [4:0] key_idx;

   // split the event byte
   always_comb
   begin
      key_id      = kbd_event[6:0];
      is_break    = kbd_event[KBD_BREAK_BIT];
      id_in_range = (key_id >= KEY_ID_FIRST) && (key_id <= KEY_ID_LAST);
      key_idx     = 5'(KEY_ID_LAST - key_id);   // id 1 lands on the top bit
   end

   ////////////////////////////////////////////////////////////////////////////
   // held flags
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         keys <= '0;   // everything released
      end
      else if (kbd_event_valid && id_in_range)
      begin
         keys[key_idx] <= ~is_break;   // make sets, break clears
      end
   end

   // ids outside 1..17 fall through untouched

endmodule

// File: source/dds_lab_pkg.sv
package dds_lab_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // datapath types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic signed [11:0] sample_t;   // one signed wave sample
   typedef logic [31:0]        phase_t;    // accumulator and its increment

   localparam sample_t SAMPLE_MAX = 12'h7FF;
   localparam sample_t SAMPLE_MIN = 12'h800;

   typedef enum logic [1:0] {
      WAVE_SAW      = 2'd0,
      WAVE_SAW_INV  = 2'd1,
      WAVE_TRIANGLE = 2'd2,
      WAVE_SQUARE   = 2'd3
   } wave_sel_e;

   typedef enum logic [1:0] {
      MOD_ASK      = 2'd0,
      MOD_BPSK     = 2'd1,
      MOD_LFSR_BIT = 2'd2,
      MOD_OFF      = 2'd3
   } mod_sel_e;

   // control register as seen by the datapath, bits 4..0
   typedef struct packed {
      logic      enable;
      mod_sel_e  mod_sel;
      wave_sel_e wave_sel;
   } dds_ctrl_t;

   ////////////////////////////////////////////////////////////////////////////
   // keyboard
   ////////////////////////////////////////////////////////////////////////////

   localparam int KEY_COUNT = 17;
   typedef logic [KEY_COUNT-1:0] key_vec_t;  // bit 16 is key 1, bit 0 is down arrow
   typedef logic [7:0]           kbd_event_t;

   localparam int         KBD_BREAK_BIT = 7;      // set on release
   localparam logic [6:0] KEY_ID_FIRST  = 7'd1;
   localparam logic [6:0] KEY_ID_LAST   = 7'd17;

   ////////////////////////////////////////////////////////////////////////////
   // register map
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [3:0]  axil_addr_t;
   typedef logic [31:0] axil_data_t;

   localparam axil_addr_t REG_CTRL      = 4'h0;
   localparam axil_addr_t REG_PHASE_INC = 4'h4;
   localparam axil_addr_t REG_KEYS      = 4'h8;  // read only
   localparam axil_addr_t REG_LFSR      = 4'hC;  // read only

   localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

   // lfsr stepping
   localparam logic [15:0] LFSR_TICK_DIV = 16'd50;
   localparam logic [4:0]  LFSR_SEED     = 5'b00001;
   localparam logic [4:0]  LFSR_TAPS     = 5'b10100;  // x^5 + x^3 + 1

endpackage
